// File: huffman.f
+incdir+.
huffman_pkg.sv
huffman_ctrl_pkg.sv
freq_counter.sv
count_sorter.sv
tree_merger.sv
code_builder.sv
huffman.sv
tb_huffman.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_huffman -f huffman.f

out=$(./obj_dir/Vtb_huffman 2>&1) || true
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

// File: tb_huffman_model.svh
`ifndef TB_HUFFMAN_MODEL_SVH
`define TB_HUFFMAN_MODEL_SVH

typedef logic [NUM_SYMBOLS-1:0][CNT_W-1:0] count_vec_t;     // entry k is symbol k+1
typedef logic [NUM_MERGES-1:0][NUM_SYMBOLS-1:0] pair_vec_t;  // entry j is merge step j

// one sample into the running counts, values outside 1..6 drop out
function automatic count_vec_t count_sample(count_vec_t c, sample_t d);
	count_vec_t r;
	r = c;
	for (int k = 0; k < NUM_SYMBOLS; k++) begin
		if (d == sample_t'(k + 1))
			r[k] = r[k] + count_t'(1);
	end
	return r;
endfunction

// smaller count first, higher symbol first on a tie
function automatic bit lighter(count_t ca, int sa, count_t cb, int sb);
	return (ca < cb) || ((ca == cb) && (sa > sb));
endfunction

function automatic void build_pairs(count_vec_t c, output pair_vec_t one,
		output pair_vec_t zero);
	count_t lc [NUM_SYMBOLS];
	mask_t  lm [NUM_SYMBOLS];
	bit     used [NUM_SYMBOLS];
	int     best;
	int     len;
	int     slot;
	count_t sum;
	mask_t  joined;
	for (int k = 0; k < NUM_SYMBOLS; k++) begin
		used[k] = 1'b0;
	end
	// pick the lightest leaf left for each position
	for (int p = 0; p < NUM_SYMBOLS; p++) begin
		best = -1;
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			if (!used[k] && (best < 0 || lighter(c[k], k, c[best], best)))
				best = k;
		end
		used[best] = 1'b1;
		lc[p] = c[best];
		lm[p] = mask_t'(1) << best;
	end
	len = NUM_SYMBOLS;
	for (int j = 0; j < NUM_MERGES; j++) begin
		one[j]  = lm[0];
		zero[j] = lm[1];
		sum     = lc[0] + lc[1];
		joined  = lm[0] | lm[1];
		for (int i = 0; i < NUM_SYMBOLS - 2; i++) begin
			lc[i] = lc[i + 2];
			lm[i] = lm[i + 2];
		end
		len  = len - 2;
		slot = 0;
		while (slot < len && lc[slot] < sum)
			slot++;   // goes ahead of first node not lighter
		for (int i = len; i > slot; i--) begin
			lc[i] = lc[i - 1];
			lm[i] = lm[i - 1];
		end
		lc[slot] = sum;
		lm[slot] = joined;
		len++;
	end
endfunction

// root merge first, every hit appends one bit at the low end
function automatic void build_code(pair_vec_t one, pair_vec_t zero, int s,
		output code_t hc_e, output code_t m_e);
	hc_e = '0;
	m_e  = '0;
	for (int j = NUM_MERGES - 1; j >= 0; j--) begin
		if (one[j][s] || zero[j][s]) begin
			hc_e = (hc_e << 1) | code_t'(one[j][s]);
			m_e  = (m_e << 1) | code_t'(1);
		end
	end
endfunction

function automatic int code_len(code_t mk);
	int n;
	n = 0;
	for (int b = 0; b < CODE_W; b++) begin
		if (mk[b])
			n++;
	end
	return n;
endfunction

`endif

// File: tb_huffman.sv
module tb_huffman;
	import huffman_pkg::*;

	`include "tb_huffman_model.svh"

	localparam int CLK_PERIOD       = 100;
	localparam int RESET_CYCLES     = 4;
	localparam int RANDOM_FRAMES    = 12;
	localparam int NUM_FRAMES       = RANDOM_FRAMES + 2;   // two tie frames
	localparam int CYCLES_PER_FRAME = 4000;
	localparam int GAP_CYCLES       = 4;
	localparam int MIN_BURST        = 20;
	localparam int MAX_BURST        = 60;
	localparam int unsigned SEED    = 32'hd8a8_79df;

	logic    clk;
	logic    reset;
	logic    gray_valid;
	sample_t gray_data;
	logic    cnt_valid;
	count_t  cnt [NUM_SYMBOLS];
	logic    code_valid;
	code_t   hc [NUM_SYMBOLS];
	code_t   m [NUM_SYMBOLS];

	sample_t burst_q [$];
	int      code_pulses;
	int      frames_done;

	huffman huffman_i (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.cnt        (cnt),
		.code_valid (code_valid),
		.hc         (hc),
		.m          (m)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (CYCLES_PER_FRAME * NUM_FRAMES + RESET_CYCLES));
		report_problem("watchdog expired before all frames were coded");
	end

	// ========================================
	// failure reporting
	// ========================================
	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(string name, int idx, code_t got, code_t expected);
		$display("[ERROR] %s[%0d] = 0x%0h, expected 0x%0h", name, idx, got, expected);
		abort_run();
	endtask

	task automatic report_problem(string what);
		$display("[ERROR] %s", what);
		abort_run();
	endtask

	// ========================================
	// protocol checks
	// ========================================
	assert property (@(posedge clk) disable iff (reset) $fell(gray_valid) |=> cnt_valid)
		else report_problem("cnt_valid missing one cycle after the burst ended");
	assert property (@(posedge clk) disable iff (reset)
		cnt_valid |-> !$past(gray_valid) && $past(gray_valid, 2))
		else report_problem("cnt_valid pulsed without a burst ending");
	assert property (@(posedge clk) disable iff (reset) cnt_valid |=> !cnt_valid)
		else report_problem("cnt_valid lasted more than one cycle");
	assert property (@(posedge clk) disable iff (reset) code_valid |=> !code_valid)
		else report_problem("code_valid lasted more than one cycle");

	always @(posedge clk) begin
		if (reset)
			code_pulses <= 0;
		else if (code_valid)
			code_pulses <= code_pulses + 1;
	end

	task automatic check_idle(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!cnt_valid && !code_valid)
				else report_problem("a valid pulse appeared before the first burst");
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				assert (cnt[k] == '0) else report_value("cnt", k, code_t'(cnt[k]), '0);
				assert (hc[k] == '0) else report_value("hc", k, hc[k], '0);
				assert (m[k] == '0) else report_value("m", k, m[k], '0);
			end
		end
	endtask

	task automatic check_counts(count_vec_t exp_cnt);
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			assert (cnt[k] == exp_cnt[k])
				else report_value("cnt", k, code_t'(cnt[k]), code_t'(exp_cnt[k]));
		end
	endtask

	// masks are runs from bit 0, no code starts another
	task automatic check_code_shape();
		int len_s;
		int len_t;
		for (int s = 0; s < NUM_SYMBOLS; s++) begin
			len_s = code_len(m[s]);
			assert (len_s > 0) else report_problem("a symbol got an empty code");
			assert (m[s] == code_t'((32'd1 << len_s) - 32'd1))
				else report_value("m", s, m[s], code_t'((32'd1 << len_s) - 32'd1));
			for (int t = 0; t < NUM_SYMBOLS; t++) begin
				len_t = code_len(m[t]);
				if (t != s && len_s <= len_t)
					assert ((hc[t] >> (len_t - len_s)) != hc[s])
						else report_problem($sformatf("code of symbol %0d is a prefix of symbol %0d",
							s + 1, t + 1));
			end
		end
	endtask

	// ========================================
	// frame stimulus
	// ========================================
	task automatic fill_random_burst();
		int n;
		n = MIN_BURST + int'($urandom_range(MAX_BURST - MIN_BURST));
		burst_q.delete();
		repeat (n) begin
			burst_q.push_back(sample_t'($urandom_range(9)));   // 0 and 7..9 are ignored
		end
	endtask

	task automatic run_frame();
		count_vec_t exp_cnt;
		pair_vec_t  exp_one;
		pair_vec_t  exp_zero;
		code_t      exp_hc;
		code_t      exp_m;
		exp_cnt = '0;
		foreach (burst_q[i]) begin
			@(negedge clk);
			gray_valid = 1'b1;
			gray_data  = burst_q[i];
			exp_cnt    = count_sample(exp_cnt, burst_q[i]);
		end
		@(negedge clk);
		gray_valid = 1'b0;
		gray_data  = '0;
		@(negedge clk);
		assert (cnt_valid) else report_problem("cnt_valid not seen after the burst");
		check_counts(exp_cnt);
		while (!code_valid)
			@(negedge clk);
		check_counts(exp_cnt);   // counts hold during coding
		build_pairs(exp_cnt, exp_one, exp_zero);
		for (int s = 0; s < NUM_SYMBOLS; s++) begin
			build_code(exp_one, exp_zero, s, exp_hc, exp_m);
			assert (hc[s] == exp_hc) else report_value("hc", s, hc[s], exp_hc);
			assert (m[s] == exp_m) else report_value("m", s, m[s], exp_m);
		end
		check_code_shape();
		frames_done++;
		repeat (GAP_CYCLES) @(negedge clk);
		assert (code_pulses == frames_done)
			else report_problem("number of code_valid pulses differs from frames sent");
	endtask

	initial begin
		void'($urandom(SEED));
		reset       = 1'b1;
		gray_valid  = 1'b0;
		gray_data   = '0;
		frames_done = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		check_idle(2 * GAP_CYCLES);
		for (int f = 0; f < RANDOM_FRAMES; f++) begin
			fill_random_burst();
			run_frame();
		end
		// every symbol eight times
		burst_q.delete();
		for (int r = 0; r < 8; r++) begin
			for (int k = 1; k <= NUM_SYMBOLS; k++) begin
				burst_q.push_back(sample_t'(k));
			end
		end
		run_frame();
		// only symbols 2 and 5, the rest stay at zero
		burst_q.delete();
		for (int r = 0; r < 12; r++) begin
			burst_q.push_back(sample_t'(2));
			burst_q.push_back((r % 2 == 0) ? 8'd5 : 8'hff);
		end
		run_frame();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: huffman.sv
module huffman (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 gray_valid,
	input  huffman_pkg::sample_t gray_data,
	output logic                 cnt_valid,
	output huffman_pkg::count_t  cnt [huffman_pkg::NUM_SYMBOLS],
	output logic                 code_valid,
	output huffman_pkg::code_t   hc [huffman_pkg::NUM_SYMBOLS],
	output huffman_pkg::code_t   m [huffman_pkg::NUM_SYMBOLS]
);
	import huffman_pkg::*;

	// ========================================
	// stage links
	// ========================================
	count_t sorted_cnt [NUM_SYMBOLS];
	mask_t  sorted_mask [NUM_SYMBOLS];
	logic   sort_done;
	mask_t  pair_one [NUM_MERGES];
	mask_t  pair_zero [NUM_MERGES];
	logic   merge_done;

	freq_counter freq_counter_i (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.frame_done (code_valid),    // reopens input for next frame
		.cnt        (cnt),
		.cnt_valid  (cnt_valid)
	);

	count_sorter count_sorter_i (
		.clk         (clk),
		.reset       (reset),
		.cnt_valid   (cnt_valid),
		.cnt         (cnt),
		.sorted_cnt  (sorted_cnt),
		.sorted_mask (sorted_mask),
		.sort_done   (sort_done)
	);

	tree_merger tree_merger_i (
		.clk         (clk),
		.reset       (reset),
		.sort_done   (sort_done),
		.sorted_cnt  (sorted_cnt),
		.sorted_mask (sorted_mask),
		.pair_one    (pair_one),
		.pair_zero   (pair_zero),
		.merge_done  (merge_done)
	);

	code_builder code_builder_i (
		.clk        (clk),
		.reset      (reset),
		.merge_done (merge_done),
		.pair_one   (pair_one),
		.pair_zero  (pair_zero),
		.hc         (hc),
		.m          (m),
		.code_valid (code_valid)
	);

endmodule

// File: code_builder.sv
module code_builder (
	input  logic               clk,
	input  logic               reset,
	input  logic               merge_done,
	input  huffman_pkg::mask_t pair_one [huffman_pkg::NUM_MERGES],
	input  huffman_pkg::mask_t pair_zero [huffman_pkg::NUM_MERGES],
	output huffman_pkg::code_t hc [huffman_pkg::NUM_SYMBOLS],
	output huffman_pkg::code_t m [huffman_pkg::NUM_SYMBOLS],
	output logic               code_valid
);
	import huffman_pkg::*;

	logic  active;
	idx_t  step;        // runs from root merge down to the first merge
	mask_t hit;         // symbols under either side of this merge

	assign hit = pair_one[step] | pair_zero[step];

	// ========================================
	// root to leaf walk
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			active     <= 1'b0;
			step       <= '0;
			code_valid <= 1'b0;
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				hc[s] <= '0;
				m[s]  <= '0;
			end
		end else begin
			code_valid <= active && (step == '0);   // after the last step
			if (merge_done) begin
				active <= 1'b1;
				step   <= idx_t'(NUM_MERGES - 1);
				for (int s = 0; s < NUM_SYMBOLS; s++) begin
					hc[s] <= '0;   // new tree, old codes go
					m[s]  <= '0;
				end
			end else if (active) begin
				for (int s = 0; s < NUM_SYMBOLS; s++) begin
					if (hit[s]) begin
						// earlier bits move up, root ends on top
						hc[s] <= {hc[s][CODE_W-2:0], pair_one[step][s]};
						m[s]  <= {m[s][CODE_W-2:0], 1'b1};
					end
				end
				if (step == '0)
					active <= 1'b0;
				else
					step <= step - idx_t'(1);
			end
		end
	end

endmodule

// File: tree_merger.sv
module tree_merger (
	input  logic                clk,
	input  logic                reset,
	input  logic                sort_done,
	input  huffman_pkg::count_t sorted_cnt [huffman_pkg::NUM_SYMBOLS],
	input  huffman_pkg::mask_t  sorted_mask [huffman_pkg::NUM_SYMBOLS],
	output huffman_pkg::mask_t  pair_one [huffman_pkg::NUM_MERGES],
	output huffman_pkg::mask_t  pair_zero [huffman_pkg::NUM_MERGES],
	output logic                merge_done
);
	import huffman_pkg::*;
	import huffman_ctrl_pkg::*;

	merger_state_t state;
	count_t        lst_cnt [NUM_SYMBOLS];    // lightest first
	mask_t         lst_mask [NUM_SYMBOLS];
	count_t        new_cnt;                  // node waiting for its slot
	mask_t         new_mask;
	idx_t          len;                      // valid entries in the list
	idx_t          pos;                      // insertion probe
	idx_t          step;                     // merge index j
	logic          place;

	// end of list or first entry not lighter than the new node
	assign place = (pos == len) || (lst_cnt[pos] >= new_cnt);

	assign merge_done = (state == merge_finish);

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= merge_idle;
			len   <= '0;
			pos   <= '0;
			step  <= '0;
		end else begin
			case (state)
				merge_idle: begin
					if (sort_done) begin
						state <= merge_combine;
						len   <= idx_t'(NUM_SYMBOLS);
						step  <= '0;
					end
				end
				merge_combine: begin
					len   <= len - idx_t'(2);   // two nodes leave
					pos   <= '0;
					state <= merge_insert;
				end
				merge_insert: begin
					if (place) begin
						len <= len + idx_t'(1);
						if (step == idx_t'(NUM_MERGES - 1)) begin
							state <= merge_finish;
						end else begin
							step  <= step + idx_t'(1);
							state <= merge_combine;
						end
					end else begin
						pos <= pos + idx_t'(1);   // one entry per cycle
					end
				end
				default: state <= merge_idle;
			endcase
		end
	end

	// ========================================
	// node list and recorded pairs
	// ========================================
	always_ff @(posedge clk) begin
		case (state)
			merge_idle: begin
				if (sort_done) begin
					lst_cnt  <= sorted_cnt;
					lst_mask <= sorted_mask;
				end
			end
			merge_combine: begin
				pair_one[step]  <= lst_mask[0];   // lightest
				pair_zero[step] <= lst_mask[1];
				new_cnt         <= lst_cnt[0] + lst_cnt[1];
				new_mask        <= lst_mask[0] | lst_mask[1];
				// close the gap at the head
				for (int i = 0; i < NUM_SYMBOLS - 2; i++) begin
					lst_cnt[i]  <= lst_cnt[i + 2];
					lst_mask[i] <= lst_mask[i + 2];
				end
			end
			merge_insert: begin
				if (place) begin
					// open a hole at pos, rest keeps its order
					for (int i = 1; i < NUM_SYMBOLS; i++) begin
						if (idx_t'(i) > pos) begin
							lst_cnt[i]  <= lst_cnt[i - 1];
							lst_mask[i] <= lst_mask[i - 1];
						end
					end
					lst_cnt[pos]  <= new_cnt;
					lst_mask[pos] <= new_mask;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: count_sorter.sv
module count_sorter (
	input  logic                clk,
	input  logic                reset,
	input  logic                cnt_valid,
	input  huffman_pkg::count_t cnt [huffman_pkg::NUM_SYMBOLS],
	output huffman_pkg::count_t sorted_cnt [huffman_pkg::NUM_SYMBOLS],
	output huffman_pkg::mask_t  sorted_mask [huffman_pkg::NUM_SYMBOLS],
	output logic                sort_done
);
	import huffman_pkg::*;
	import huffman_ctrl_pkg::*;

	sorter_state_t state;
	count_t        node_cnt [NUM_SYMBOLS];
	mask_t         node_mask [NUM_SYMBOLS];
	idx_t          pos;          // left node of the compared pair
	idx_t          next_pos;
	logic          pass_swap;    // any swap so far in this pass
	logic          do_swap;
	logic          pass_end;
	count_t        cnt_a;
	count_t        cnt_b;
	mask_t         mask_a;
	mask_t         mask_b;

	// ========================================
	// shared comparator
	// ========================================
	assign cnt_a  = node_cnt[pos];
	assign cnt_b  = node_cnt[pos + idx_t'(1)];
	assign mask_a = node_mask[pos];
	assign mask_b = node_mask[pos + idx_t'(1)];

	// right node lighter -> swap; on a tie the higher symbol is lighter
	assign do_swap = (cnt_b < cnt_a) || ((cnt_b == cnt_a) && (mask_b > mask_a));

	// order of pairs is 0,2,4 then 1,3
	assign next_pos = pos + idx_t'(2);
	assign pass_end = pos[0] && (next_pos > idx_t'(NUM_SYMBOLS - 2));

	assign sort_done   = (state == sort_finish);
	assign sorted_cnt  = node_cnt;
	assign sorted_mask = node_mask;

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= sort_idle;
			pos       <= '0;
			pass_swap <= 1'b0;
		end else begin
			case (state)
				sort_idle: begin
					if (cnt_valid) begin
						state     <= sort_compare;
						pos       <= '0;
						pass_swap <= 1'b0;
					end
				end
				sort_compare: begin
					if (pass_end) begin
						pos       <= '0;
						pass_swap <= 1'b0;
						if (!(pass_swap || do_swap))
							state <= sort_finish;   // clean pass, list ordered
					end else if (next_pos > idx_t'(NUM_SYMBOLS - 2)) begin
						pos       <= idx_t'(1);     // even phase done
						pass_swap <= pass_swap || do_swap;
					end else begin
						pos       <= next_pos;
						pass_swap <= pass_swap || do_swap;
					end
				end
				default: state <= sort_idle;        // finish lasts one cycle
			endcase
		end
	end

	// ========================================
	// node storage
	// ========================================
	always_ff @(posedge clk) begin
		if (state == sort_idle && cnt_valid) begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				node_cnt[k]  <= cnt[k];
				node_mask[k] <= mask_t'(1) << k;   // one leaf per symbol
			end
		end else if (state == sort_compare && do_swap) begin
			node_cnt[pos]               <= cnt_b;
			node_mask[pos]              <= mask_b;
			node_cnt[pos + idx_t'(1)]   <= cnt_a;
			node_mask[pos + idx_t'(1)]  <= mask_a;
		end
	end

endmodule

// File: freq_counter.sv
module freq_counter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 gray_valid,
	input  huffman_pkg::sample_t gray_data,
	input  logic                 frame_done,
	output huffman_pkg::count_t  cnt [huffman_pkg::NUM_SYMBOLS],
	output logic                 cnt_valid
);
	import huffman_pkg::*;
	import huffman_ctrl_pkg::*;

	counter_state_t state;
	logic           gray_valid_q;   // for burst start detect
	logic           busy;           // frame still in the later stages
	logic           start;

	// only a fresh rising edge opens a frame
	assign start = gray_valid && !gray_valid_q && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= cnt_idle;
			gray_valid_q <= 1'b0;
			busy         <= 1'b0;
			cnt_valid    <= 1'b0;
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				cnt[k] <= '0;
			end
		end else begin
			gray_valid_q <= gray_valid;
			cnt_valid    <= 1'b0;
			case (state)
				cnt_idle: begin
					if (start) begin
						// first sample also counts
						for (int k = 0; k < NUM_SYMBOLS; k++) begin
							cnt[k] <= (gray_data == sample_t'(k + 1)) ? count_t'(1) : '0;
						end
						state <= cnt_receive;
					end
				end
				cnt_receive: begin
					if (gray_valid) begin
						for (int k = 0; k < NUM_SYMBOLS; k++) begin
							if (gray_data == sample_t'(k + 1))
								cnt[k] <= cnt[k] + count_t'(1);
						end
					end else begin
						cnt_valid <= 1'b1;   // burst over
						busy      <= 1'b1;
						state     <= cnt_idle;
					end
				end
				default: state <= cnt_idle;
			endcase
			if (frame_done)
				busy <= 1'b0;
		end
	end

endmodule

// File: huffman_ctrl_pkg.sv
package huffman_ctrl_pkg;

	// ========================================
	// sequencing state machines
	// ========================================
	typedef enum logic [1:0] {
		sort_idle,
		sort_compare,     // one pair per cycle
		sort_finish
	} sorter_state_t;

	typedef enum logic [1:0] {
		merge_idle,
		merge_combine,    // take two lightest
		merge_insert,     // walk list for slot
		merge_finish
	} merger_state_t;

	typedef enum logic {
		cnt_idle,
		cnt_receive
	} counter_state_t;

endpackage

// File: huffman_pkg.sv
package huffman_pkg;

	// ========================================
	// alphabet and widths
	// ========================================
	localparam int NUM_SYMBOLS = 6;
	localparam int NUM_MERGES  = NUM_SYMBOLS - 1;
	localparam int CNT_W       = 8;
	localparam int CODE_W      = 8;
	localparam int SAMPLE_W    = 8;

	// node positions, merge steps and list lengths all fit here
	localparam int IDX_W = $clog2(NUM_SYMBOLS + 1);

	// ========================================
	// data types
	// ========================================
	typedef logic [CNT_W-1:0] count_t;

	// bit k is symbol k+1
	typedef logic [NUM_SYMBOLS-1:0] mask_t;

	typedef logic [CODE_W-1:0] code_t;       // code word or length mask

	typedef logic [SAMPLE_W-1:0] sample_t;

	typedef logic [IDX_W-1:0] idx_t;

endpackage
